// File: lane_driver.f
common/lane_geom_pkg.sv
common/lane_inst_pkg.sv
sequencer/lane_sequencer.sv
logic/vrf_addr_counter.sv
logic/byte_enable_gen.sv
logic/read_valid_tracker.sv
logic/lane_driver.sv
sim/lane_driver_chk.sv
sim/lane_driver_tb.sv

// File: Makefile
FILELIST := lane_driver.f

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --top-module lane_driver \
		common/lane_geom_pkg.sv common/lane_inst_pkg.sv sequencer/lane_sequencer.sv \
		logic/vrf_addr_counter.sv logic/byte_enable_gen.sv logic/read_valid_tracker.sv \
		logic/lane_driver.sv

sim:
	verilator --binary --timing --top-module lane_driver_tb -f $(FILELIST)
	@out="$$(./obj_dir/Vlane_driver_tb)"; echo "$$out"; \
		echo "$$out" | grep -q "^Regression passed$$"

clean:
	rm -rf obj_dir

// File: sim/lane_driver_tb.sv
`timescale 1ns/1ns
`default_nettype none

module lane_driver_tb
    import lane_geom_pkg::*;
    import lane_inst_pkg::*;
();

    localparam int LANES           = LANES_DEF;
    localparam int CLK_PERIOD      = 100;
    localparam int RESET_CYCLES    = 10;
    localparam int N_INST          = 60;
    localparam int SEED            = 37186;
    localparam int WATCHDOG_CYCLES = N_INST * (255 + 256 + 20) + RESET_CYCLES;

    logic                   clk_i;
    logic                   rst_i;
    logic                   start_i;
    inst_kind_t             kind_i;
    vl_t                    vl_i;
    ew_t                    vsew_i;
    ew_t                    wdata_ew_i;
    delay_t                 delay_i;
    logic                   mask_en_i;
    addr_t [N_OPERANDS-1:0] start_raddr_i;
    addr_t                  start_waddr_i;
    logic                   load_valid_i;
    logic                   load_last_i;
    bwen_t [LANES-1:0]      load_bwen_i;
    logic                   ready_o;
    logic                   ready_for_load_o;
    logic                   store_data_valid_o;
    logic [LANES-1:0]       read_valid_o;
    addr_t [N_OPERANDS-1:0] vrf_raddr_o;
    addr_t                  vrf_waddr_o;
    bwen_t [LANES-1:0]      vrf_bwen_o;
    step_t                  vmrf_addr_o;
    logic                   vmrf_wen_o;

    int    errors = 0;
    int    checks = 0;
    int    issued = 0;        // Instructions the model started
    int    seen_accepts = 0;  // Handshakes seen on the ports
    string test_name = "reset";

    lane_driver #(.LANES(LANES)) lane_driver_inst (.*);

    bind lane_driver lane_driver_chk #(.LANES(LANES)) chk_inst (
        .clk_i, .rst_i, .ready_o, .store_data_valid_o, .ready_for_load_o,
        .read_valid_o, .vrf_bwen_o
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    always @(negedge clk_i) begin
        #(CLK_PERIOD / 4);
        if (rst_i && start_i && ready_o) seen_accepts++;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Regression failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////
    function automatic int read_cycles(input int vl);
        return (vl + LANES - 1) / LANES;
    endfunction

    function automatic int lane_elems(input int vl, input int lane);
        return vl / LANES + ((lane < vl % LANES) ? 1 : 0);
    endfunction

    function automatic int elem_shift(input ew_t ew);
        case (ew)
            EW_BYTE: return 2;
            EW_HALF: return 1;
            default: return 0;
        endcase
    endfunction

    function automatic bwen_t bwen_pattern(input ew_t ew, input int w);
        case (ew)
            EW_BYTE: return bwen_t'(1 << (w % 4));  // Walks up one byte per write
            EW_HALF: return (w % 2 == 0) ? 4'b0011 : 4'b1100;
            EW_WORD: return 4'b1111;
            default: return 4'b0000;
        endcase
    endfunction

    function automatic bit chance(input int unsigned pct);
        return $urandom_range(0, 99) < pct;
    endfunction

    ////////////////////////////////////////////////////////////
    // Checks and stimulus
    ////////////////////////////////////////////////////////////
    task automatic compare(input string field, input int t,
                           input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("[FAIL] %s %s step %0d: expected %0h, actual %0h",
                     test_name, field, t, expected, actual);
        end
    endtask

    task automatic expect_quiet(input int t, input bit exp_ready, input bit exp_load_rdy);
        compare("ready_o", t, 32'(exp_ready), 32'(ready_o));
        compare("ready_for_load_o", t, 32'(exp_load_rdy), 32'(ready_for_load_o));
        compare("read_valid_o", t, 0, 32'(read_valid_o));
        compare("store_data_valid_o", t, 0, 32'(store_data_valid_o));
        compare("vmrf_wen_o", t, 0, 32'(vmrf_wen_o));
    endtask

    task automatic verify_reads(input int t, input int vl, input int sh,
                                input addr_t [N_OPERANDS-1:0] base);
        logic [LANES-1:0] exp_valid;
        for (int i = 0; i < LANES; i++) begin
            exp_valid[i] = (t < lane_elems(vl, i));
        end
        compare("read_valid_o", t, 32'(exp_valid), 32'(read_valid_o));
        for (int p = 0; p < N_OPERANDS; p++) begin
            compare($sformatf("vrf_raddr_o[%0d]", p), t,
                    32'(addr_t'(int'(base[p]) + (t >> sh))), 32'(vrf_raddr_o[p]));
        end
    endtask

    // New random values on every input even while busy
    task automatic randomize_inputs(input bit start);
        start_i       = start;
        kind_i        = inst_kind_t'($urandom_range(0, 3));
        vl_i          = vl_t'(chance(25) ? $urandom_range(1, 2048) : $urandom_range(1, 40));
        delay_i       = delay_t'(chance(25) ? $urandom_range(0, 255) : $urandom_range(0, 8));
        vsew_i        = ew_t'($urandom_range(0, 3));
        wdata_ew_i    = ew_t'($urandom_range(0, 3));
        mask_en_i     = chance(50);
        start_waddr_i = addr_t'($urandom_range(0, MEM_DEPTH - 1));
        load_valid_i  = chance(50);
        load_last_i   = chance(50);
        for (int p = 0; p < N_OPERANDS; p++) begin
            start_raddr_i[p] = addr_t'($urandom_range(0, MEM_DEPTH - 1));
        end
        for (int l = 0; l < LANES; l++) begin
            load_bwen_i[l] = bwen_t'($urandom_range(0, 15));
        end
    endtask

    task automatic issue_instruction(input int n);
        inst_kind_t             k;
        ew_t                    wew;
        bit                     mask;
        bit                     reads;
        addr_t [N_OPERANDS-1:0] rbase;
        addr_t                  wbase;
        int                     vl;
        int                     r;
        int                     d;
        int                     rsh;
        int                     wsh;
        int                     last;
        int                     beats;
        int                     beat;
        int                     gaps;
        int                     t;

        @(negedge clk_i);
        randomize_inputs(1'b1);
        k      = chance(10) ? inst_kind_t'(3) : inst_kind_t'($urandom_range(0, 2));
        kind_i = k;
        vl     = int'(vl_i);
        r      = read_cycles(vl);
        d      = int'(delay_i);
        rsh    = elem_shift(vsew_i);
        wew    = wdata_ew_i;
        wsh    = elem_shift(wdata_ew_i);
        mask   = mask_en_i;
        rbase  = start_raddr_i;
        wbase  = start_waddr_i;
        reads  = (k == KIND_NORMAL) || (k == KIND_STORE);
        test_name = $sformatf("inst %0d kind %0d", n, k);
        issued++;
        #(CLK_PERIOD / 4);
        expect_quiet(-1, 1'b1, 1'b0);
        compare("vrf_bwen_o", -1, 0, 32'(vrf_bwen_o));

        if (k == KIND_LOAD) begin
            beats = $urandom_range(1, 16);
            beat  = 0;
            gaps  = 0;
            t     = 0;
            while (beat < beats) begin
                @(negedge clk_i);
                randomize_inputs(chance(25));
                load_valid_i = (gaps >= 3) || chance(60);  // Bounded back-pressure gaps
                load_last_i  = load_valid_i ? (beat == beats - 1) : chance(50);
                #(CLK_PERIOD / 4);
                expect_quiet(t, 1'b0, 1'b1);
                if (load_valid_i) begin
                    compare("vrf_waddr_o", t, 32'(addr_t'(int'(wbase) + beat)),
                            32'(vrf_waddr_o));
                    for (int l = 0; l < LANES; l++) begin
                        compare($sformatf("vrf_bwen_o[%0d]", l), t,
                                32'(load_bwen_i[l]), 32'(vrf_bwen_o[l]));
                    end
                    beat++;
                    gaps = 0;
                end else begin
                    compare("vrf_bwen_o", t, 0, 32'(vrf_bwen_o));
                    gaps++;
                end
                t++;
            end
            @(negedge clk_i);
            randomize_inputs(1'b0);
            #(CLK_PERIOD / 4);
            expect_quiet(t, 1'b1, 1'b0);
        end else begin
            // Last step with ready low
            last = (k == KIND_NORMAL) ? d + r : ((k == KIND_STORE) ? r - 1 : 0);
            for (t = 0; t <= last + 1; t++) begin
                @(negedge clk_i);
                randomize_inputs((t <= last) && chance(25));
                #(CLK_PERIOD / 4);
                compare("ready_o", t, 32'(t > last), 32'(ready_o));
                compare("ready_for_load_o", t, 0, 32'(ready_for_load_o));
                compare("store_data_valid_o", t, 32'((k == KIND_STORE) && (t <= last)),
                        32'(store_data_valid_o));
                if (reads && (t < r)) begin
                    verify_reads(t, vl, rsh, rbase);
                end else begin
                    compare("read_valid_o", t, 0, 32'(read_valid_o));
                end
                if ((k == KIND_NORMAL) && (t > d) && (t <= last)) begin
                    compare("vrf_waddr_o", t, 32'(addr_t'(int'(wbase) + ((t - d - 1) >> wsh))),
                            32'(vrf_waddr_o));
                    compare("vmrf_addr_o", t, t - d - 1, 32'(vmrf_addr_o));
                    compare("vmrf_wen_o", t, 32'(mask), 32'(vmrf_wen_o));
                    for (int l = 0; l < LANES; l++) begin
                        compare($sformatf("vrf_bwen_o[%0d]", l), t,
                                32'(bwen_pattern(wew, t - d - 1)), 32'(vrf_bwen_o[l]));
                    end
                end else begin
                    compare("vrf_bwen_o", t, 0, 32'(vrf_bwen_o));
                    compare("vmrf_wen_o", t, 0, 32'(vmrf_wen_o));
                end
            end
        end
    endtask

    initial begin
        void'($urandom(SEED));
        rst_i         = 1'b0;
        start_i       = 1'b0;
        kind_i        = KIND_NORMAL;
        vl_i          = vl_t'(1);
        vsew_i        = EW_WORD;
        wdata_ew_i    = EW_WORD;
        delay_i       = '0;
        mask_en_i     = 1'b0;
        start_raddr_i = '0;
        start_waddr_i = '0;
        load_valid_i  = 1'b0;
        load_last_i   = 1'b0;
        load_bwen_i   = '0;

        repeat (RESET_CYCLES) @(negedge clk_i);
        rst_i = 1'b1;
        #(CLK_PERIOD / 4);
        expect_quiet(0, 1'b1, 1'b0);
        compare("vrf_bwen_o", 0, 0, 32'(vrf_bwen_o));

        for (int n = 0; n < N_INST; n++) begin
            issue_instruction(n);
        end

        @(negedge clk_i);
        #(CLK_PERIOD / 4);
        test_name = "handshake";
        compare("accepted instructions", 0, issued, seen_accepts);

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/lane_driver_chk.sv
`timescale 1ns/1ns
`default_nettype none

module lane_driver_chk
    import lane_geom_pkg::*;
#(
    parameter int LANES = LANES_DEF
) (
    input wire                    clk_i,
    input wire                    rst_i,
    input wire                    ready_o,
    input wire                    store_data_valid_o,
    input wire                    ready_for_load_o,
    input wire [LANES-1:0]        read_valid_o,
    input wire bwen_t [LANES-1:0] vrf_bwen_o
);

    // Writes only while an instruction is in flight
    bwen_busy_a: assert property (@(posedge clk_i) disable iff (!rst_i)
        (vrf_bwen_o != '0) |-> !ready_o)
        else $error("Byte enables raised while ready_o is high");

    store_load_a: assert property (@(posedge clk_i) disable iff (!rst_i)
        !(store_data_valid_o && ready_for_load_o))
        else $error("Store data valid and load ready both high");

    // Live lanes fill up from lane 0
    valid_order_a: assert property (@(posedge clk_i) disable iff (!rst_i)
        (read_valid_o[LANES-1:1] & ~read_valid_o[LANES-2:0]) == '0)
        else $error("Read valid lane set above a cleared lane");

    reset_ready_a: assert property (@(posedge clk_i) !rst_i |=> ready_o)
        else $error("ready_o low in the cycle after reset");

endmodule

`default_nettype wire

// File: logic/lane_driver.sv
`timescale 1ns/1ns
`default_nettype none

module lane_driver
    import lane_geom_pkg::*;
    import lane_inst_pkg::*;
#(
    parameter int LANES = LANES_DEF
) (
    input  wire                          clk_i,
    input  wire                          rst_i,

    // Instruction
    input  wire                          start_i,
    input  wire inst_kind_t              kind_i,
    input  wire vl_t                     vl_i,
    input  wire ew_t                     vsew_i,
    input  wire ew_t                     wdata_ew_i,
    input  wire delay_t                  delay_i,
    input  wire                          mask_en_i,
    input  wire addr_t [N_OPERANDS-1:0]  start_raddr_i,
    input  wire addr_t                   start_waddr_i,
    output logic                         ready_o,

    // Load unit
    input  wire                          load_valid_i,
    input  wire                          load_last_i,
    input  wire bwen_t [LANES-1:0]       load_bwen_i,
    output logic                         ready_for_load_o,

    output logic                         store_data_valid_o,
    output logic [LANES-1:0]             read_valid_o,

    // VRF and VMRF
    output addr_t [N_OPERANDS-1:0]       vrf_raddr_o,
    output addr_t                        vrf_waddr_o,
    output bwen_t [LANES-1:0]            vrf_bwen_o,
    output step_t                        vmrf_addr_o,
    output logic                         vmrf_wen_o
);

    logic  rd_load;
    logic  rd_en;
    logic  wr_load;
    logic  wr_en;
    logic  write_active;
    logic  load_write;
    ew_t   wr_ew;
    ew_t   wr_cnt_ew;
    bwen_t bwen;

    // Load beats are whole words
    assign wr_cnt_ew = (kind_i == KIND_LOAD) ? EW_WORD : wdata_ew_i;

    lane_sequencer #(.LANES(LANES)) u_seq (
        .clk_i, .rst_i, .start_i, .kind_i, .vl_i, .delay_i,
        .wr_ew_i(wdata_ew_i), .mask_en_i, .ready_o, .load_valid_i, .load_last_i,
        .rd_load_o(rd_load), .rd_en_o(rd_en), .wr_load_o(wr_load), .wr_en_o(wr_en),
        .write_active_o(write_active), .wr_ew_o(wr_ew), .load_write_o(load_write),
        .ready_for_load_o, .store_data_valid_o, .vmrf_wen_o, .vmrf_addr_o
    );

    for (genvar p = 0; p < N_OPERANDS; p++) begin : g_raddr
        vrf_addr_counter u_raddr (
            .clk_i, .rst_i, .start_addr_i(start_raddr_i[p]), .load_i(rd_load),
            .en_i(rd_en), .ew_i(vsew_i), .addr_o(vrf_raddr_o[p])
        );
    end

    vrf_addr_counter u_waddr (
        .clk_i, .rst_i, .start_addr_i(start_waddr_i), .load_i(wr_load),
        .en_i(wr_en), .ew_i(wr_cnt_ew), .addr_o(vrf_waddr_o)
    );

    byte_enable_gen u_bwen (
        .clk_i, .rst_i, .active_i(write_active), .ew_i(wr_ew), .bwen_o(bwen)
    );

    read_valid_tracker #(.LANES(LANES)) u_valid (
        .clk_i, .rst_i, .load_i(rd_load), .shift_i(rd_en), .vl_i, .valid_o(read_valid_o)
    );

    // Same pattern on every lane unless a load beat is written
    assign vrf_bwen_o = load_write ? load_bwen_i : {LANES{bwen}};

endmodule

`default_nettype wire

// File: logic/read_valid_tracker.sv
`timescale 1ns/1ns
`default_nettype none

module read_valid_tracker
    import lane_geom_pkg::*;
#(
    parameter int LANES = LANES_DEF
) (
    input  wire              clk_i,
    input  wire              rst_i,
    input  wire              load_i,   // Instruction accepted
    input  wire              shift_i,  // Read cycle
    input  wire vl_t         vl_i,
    output logic [LANES-1:0] valid_o
);

    localparam int LANE_BITS = $clog2(LANES);

    vl_t base;             // Elements every lane gets
    vl_t rem;              // Lanes with one extra
    vl_t cnt_d [LANES];
    vl_t cnt_q [LANES];
    vl_t step_q;

    assign base = vl_i >> LANE_BITS;
    assign rem  = vl_i & vl_t'(LANES - 1);

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            cnt_d[i] = (vl_t'(i) < rem) ? base + 1'b1 : base;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load_i) begin
            cnt_q <= cnt_d;
        end
    end

    // Flags show the step the sequencer is in
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            step_q  <= '0;
            valid_o <= '0;
        end else if (load_i) begin
            step_q <= '0;
            for (int i = 0; i < LANES; i++) begin
                valid_o[i] <= (cnt_d[i] != '0);
            end
        end else if (shift_i) begin
            step_q <= step_q + 1'b1;
            for (int i = 0; i < LANES; i++) begin
                valid_o[i] <= ((step_q + 1'b1) < cnt_q[i]);  // Next step still live
            end
        end else begin
            valid_o <= '0;
        end
    end

endmodule

`default_nettype wire

// File: logic/byte_enable_gen.sv
`timescale 1ns/1ns
`default_nettype none

module byte_enable_gen
    import lane_geom_pkg::*;
    import lane_inst_pkg::*;
(
    input  wire        clk_i,
    input  wire        rst_i,
    input  wire        active_i,  // Normal write cycle
    input  wire ew_t   ew_i,
    output bwen_t      bwen_o
);

    logic [3:0] rot4_q;  // Byte lane one-hot
    logic [1:0] rot2_q;  // Halfword one-hot

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            rot4_q <= 4'b0001;
            rot2_q <= 2'b01;
        end else if (!active_i) begin
            // Every write burst starts at byte 0
            rot4_q <= 4'b0001;
            rot2_q <= 2'b01;
        end else begin
            rot4_q <= {rot4_q[2:0], rot4_q[3]};
            rot2_q <= {rot2_q[0], rot2_q[1]};
        end
    end

    always_comb begin
        if (!active_i) begin
            bwen_o = '0;
        end else begin
            case (ew_i)
                EW_BYTE: bwen_o = rot4_q;
                EW_HALF: bwen_o = {{2{rot2_q[1]}}, {2{rot2_q[0]}}};
                EW_WORD: bwen_o = 4'b1111;
                default: bwen_o = '0;  // No write
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/vrf_addr_counter.sv
`timescale 1ns/1ns
`default_nettype none

module vrf_addr_counter
    import lane_geom_pkg::*;
    import lane_inst_pkg::*;
(
    input  wire        clk_i,
    input  wire        rst_i,
    input  wire addr_t start_addr_i,
    input  wire        load_i,      // Start of instruction
    input  wire        en_i,        // Advance one element
    input  wire ew_t   ew_i,
    output addr_t      addr_o
);

    addr_t      base_q;
    step_t      idx_q;     // Element index within the lane
    logic [1:0] shift_q;
    logic [1:0] shift_d;

    // Four bytes or two halfwords share one word
    always_comb begin
        case (ew_i)
            EW_BYTE:          shift_d = 2'd2;
            EW_HALF:          shift_d = 2'd1;
            EW_WORD, EW_NONE: shift_d = 2'd0;
            default:          shift_d = 2'd0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            idx_q <= '0;
        end else if (load_i) begin
            idx_q <= '0;
        end else if (en_i) begin
            idx_q <= idx_q + 1'b1;
        end
    end

    // Base and width held for the whole instruction
    always_ff @(posedge clk_i) begin
        if (load_i) begin
            base_q  <= start_addr_i;
            shift_q <= shift_d;
        end
    end

    assign addr_o = base_q + addr_t'(idx_q >> shift_q);

endmodule

`default_nettype wire

// File: sequencer/lane_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module lane_sequencer
    import lane_geom_pkg::*;
    import lane_inst_pkg::*;
#(
    parameter int LANES = LANES_DEF
) (
    input  wire        clk_i,
    input  wire        rst_i,

    // Instruction handshake
    input  wire        start_i,
    input  wire inst_kind_t kind_i,
    input  wire vl_t   vl_i,
    input  wire delay_t delay_i,
    input  wire ew_t   wr_ew_i,
    input  wire        mask_en_i,
    output logic       ready_o,

    // Load unit beats
    input  wire        load_valid_i,
    input  wire        load_last_i,

    // Counter and tracker control
    output logic       rd_load_o,
    output logic       rd_en_o,
    output logic       wr_load_o,
    output logic       wr_en_o,
    output logic       write_active_o,
    output ew_t        wr_ew_o,

    output logic       load_write_o,
    output logic       ready_for_load_o,
    output logic       store_data_valid_o,
    output logic       vmrf_wen_o,
    output step_t      vmrf_addr_o
);

    localparam int LANE_BITS = $clog2(LANES);

    typedef enum logic [1:0] {
        IDLE,
        NORMAL_RUN,
        STORE_RUN,
        LOAD_RUN
    } state_t;

    state_t state_q, state_d;

    step_t  step_q;    // Cycles since run start
    step_t  w_q;       // Write index of normal writes
    logic   ready_q;

    // Fields taken at acceptance
    step_t  r_q;       // Read cycles
    delay_t delay_q;
    ew_t    ew_q;
    logic   mask_q;

    step_t  r_d;
    step_t  wr_last;
    logic   accept;
    logic   beat;
    logic   rd_phase;
    logic   wr_phase;

    assign accept = start_i && ready_q;
    assign beat   = (state_q == LOAD_RUN) && load_valid_i;

    // ceil(vl / LANES)
    assign r_d     = step_t'((vl_i + vl_t'(LANES - 1)) >> LANE_BITS);
    assign wr_last = step_t'(delay_q) + r_q;

    assign rd_phase = ((state_q == NORMAL_RUN) || (state_q == STORE_RUN)) && (step_q < r_q);
    assign wr_phase = (state_q == NORMAL_RUN) && (step_q > step_t'(delay_q))
                      && (step_q <= wr_last);

    ////////////////////////////////////////////////////////////
    // State machine
    ////////////////////////////////////////////////////////////
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (accept) begin
                    case (kind_i)
                        KIND_NORMAL: state_d = NORMAL_RUN;
                        KIND_STORE:  state_d = STORE_RUN;
                        KIND_LOAD:   state_d = LOAD_RUN;
                        default:     state_d = IDLE;  // Costs one busy cycle
                    endcase
                end
            end
            NORMAL_RUN: begin
                if (step_q == wr_last) state_d = IDLE;  // Last write done
            end
            STORE_RUN: begin
                if (step_q == r_q - 1'b1) state_d = IDLE;
            end
            LOAD_RUN: begin
                if (beat && load_last_i) state_d = IDLE;
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q <= IDLE;
            ready_q <= 1'b1;
            step_q  <= '0;
            w_q     <= '0;
        end else begin
            state_q <= state_d;

            if (accept) begin
                ready_q <= 1'b0;
            end else if (state_d == IDLE) begin
                ready_q <= 1'b1;
            end

            if ((state_q == NORMAL_RUN) || (state_q == STORE_RUN)) begin
                step_q <= step_q + 1'b1;
            end else begin
                step_q <= '0;
            end

            if (state_q == IDLE) begin
                w_q <= '0;
            end else if (wr_phase) begin
                w_q <= w_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            r_q     <= r_d;
            delay_q <= delay_i;
            ew_q    <= wr_ew_i;
            mask_q  <= mask_en_i;
        end
    end

    ////////////////////////////////////////////////////////////
    // Outputs
    ////////////////////////////////////////////////////////////
    assign ready_o   = ready_q;
    assign rd_load_o = accept && ((kind_i == KIND_NORMAL) || (kind_i == KIND_STORE));
    assign wr_load_o = accept && ((kind_i == KIND_NORMAL) || (kind_i == KIND_LOAD));
    assign rd_en_o   = rd_phase;
    assign wr_en_o   = wr_phase || beat;  // Load beats step the write address

    assign write_active_o     = wr_phase;
    assign wr_ew_o            = ew_q;
    assign load_write_o       = beat;
    assign ready_for_load_o   = (state_q == LOAD_RUN);
    assign store_data_valid_o = (state_q == STORE_RUN);
    assign vmrf_wen_o         = wr_phase && mask_q;
    assign vmrf_addr_o        = w_q;

endmodule

`default_nettype wire

// File: common/lane_inst_pkg.sv
`default_nettype none

package lane_inst_pkg;

    // Instruction kinds with code 3 left unsupported
    typedef logic [1:0] inst_kind_t;

    localparam inst_kind_t KIND_NORMAL = 2'd0;
    localparam inst_kind_t KIND_STORE  = 2'd1;
    localparam inst_kind_t KIND_LOAD   = 2'd2;

    // Element width of reads and writes
    typedef logic [1:0] ew_t;

    localparam ew_t EW_BYTE = 2'd0;
    localparam ew_t EW_HALF = 2'd1;
    localparam ew_t EW_WORD = 2'd2;
    localparam ew_t EW_NONE = 2'd3;  // Write disabled

    // Source operands with their own read port
    localparam int N_OPERANDS = 3;

endpackage

`default_nettype wire

// File: common/lane_geom_pkg.sv
`default_nettype none

package lane_geom_pkg;

    ////////////////////////////////////////////////////////////
    // Lane group geometry
    ////////////////////////////////////////////////////////////
    localparam int LANES_DEF       = 8;    // Lanes in one group
    localparam int MEM_DEPTH       = 512;  // VRF words per lane
    localparam int MAX_VL_PER_LANE = 256;

    localparam int ADDR_W  = $clog2(MEM_DEPTH);
    localparam int VL_W    = $clog2(LANES_DEF * MAX_VL_PER_LANE) + 1;  // Holds vl of 2048
    localparam int STEP_W  = $clog2(2 * MAX_VL_PER_LANE);            // Delay plus reads
    localparam int DELAY_W = 8;
    localparam int BWEN_W  = 4;

    // Vector register file word address
    typedef logic [ADDR_W-1:0]  addr_t;
    // Vector length in elements
    typedef logic [VL_W-1:0]    vl_t;
    typedef logic [STEP_W-1:0]  step_t;   // Sequencer step
    typedef logic [DELAY_W-1:0] delay_t;  // Pipeline delay
    typedef logic [BWEN_W-1:0]  bwen_t;   // Byte enables of one lane

endpackage

`default_nettype wire
